// File: Makefile
TOP       ?= tb_matvec
SEED      ?= 86
VERILATOR ?= verilator
LOG       ?= sim.log
FILELIST  ?= matvec.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG) *.log

// File: act_loader.sv
`timescale 1ns/1ns

module act_loader (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  mv_types_pkg::addr_t     a_base,
  output mv_wb_pkg::wb_req_t      bus_req,
  input  mv_wb_pkg::wb_rsp_t      bus_rsp,
  output logic                    loaded,
  output mv_types_pkg::act_vec_t  acts
);
  import mv_types_pkg::*;

  logic     fetch_q;
  logic     loaded_q;
  addr_t    addr_q;
  row_idx_t cnt_q;
  act_vec_t acts_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_q  <= 1'b0;
      loaded_q <= 1'b0;
      addr_q   <= '0;
      cnt_q    <= '0;
    end else if (start && !fetch_q) begin
      fetch_q  <= 1'b1;
      loaded_q <= 1'b0;
      addr_q   <= a_base;
      cnt_q    <= '0;
    end else if (fetch_q && bus_rsp.ack) begin
      addr_q <= addr_q + 1'b1;
      cnt_q  <= cnt_q + 1'b1;
      // last entry closes the burst
      if (cnt_q == row_idx_t'(N_ROWS - 1)) begin
        fetch_q  <= 1'b0;
        loaded_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_q && bus_rsp.ack) begin
      acts_q[cnt_q] <= bus_rsp.dat;
    end
  end

  always_comb begin
    bus_req     = '0;
    bus_req.cyc = fetch_q;
    bus_req.stb = fetch_q;
    bus_req.adr = addr_q;
  end

  assign loaded = loaded_q;
  assign acts   = acts_q;

endmodule

// File: mac_column_array.sv
`timescale 1ns/1ns

module mac_column_array (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  mv_types_pkg::job_t      job,
  output logic                    loaders_start,
  output mv_types_pkg::addr_t     w_base,
  output mv_types_pkg::addr_t     a_base,
  input  logic                    w_loaded,
  input  logic                    a_loaded,
  output mv_types_pkg::row_idx_t  rd_row,
  input  mv_types_pkg::w_row_t    w_row,
  input  mv_types_pkg::act_vec_t  acts,
  output logic                    busy,
  output logic                    done,
  output mv_types_pkg::acc_vec_t  y_vec
);
  import mv_types_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOAD,
    S_ACC
  } seq_state_t;

  seq_state_t state_q;
  job_t       job_q;
  row_idx_t   row_q;
  logic       start_q;
  logic       done_q;
  acc_vec_t   acc_q;
  acc_vec_t   acc_sum;
  acc_vec_t   y_q;

  // one MAC per column, all sharing the activation of the current row
  always_comb begin
    for (int c = 0; c < N_COLS; c++) begin
      acc_sum[c] = acc_q[c] + acc_t'(w_row[c]) * acc_t'(acts[row_q]);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      row_q   <= '0;
      start_q <= 1'b0;
      done_q  <= 1'b0;
      y_q     <= '0;
    end else begin
      start_q <= 1'b0;
      done_q  <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (start) begin
            state_q <= S_LOAD;
            start_q <= 1'b1;
          end
        end
        S_LOAD: begin
          // loaded flags of the previous job are still up while start_q is high
          if (!start_q && w_loaded && a_loaded) begin
            state_q <= S_ACC;
            row_q   <= '0;
          end
        end
        S_ACC: begin
          row_q <= row_q + 1'b1;
          if (row_q == row_idx_t'(N_ROWS - 1)) begin
            y_q     <= acc_sum;
            done_q  <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && start) begin
      job_q <= job;
    end
    // sums start from zero on the first row
    if (state_q == S_LOAD) begin
      acc_q <= '0;
    end else if (state_q == S_ACC) begin
      acc_q <= acc_sum;
    end
  end

  assign loaders_start = start_q;
  assign w_base        = job_q.w_base;
  assign a_base        = job_q.a_base;
  assign rd_row        = row_q;
  assign busy          = (state_q != S_IDLE);
  assign done          = done_q;
  assign y_vec         = y_q;

endmodule

// File: matvec.f
mv_types_pkg.sv
mv_wb_pkg.sv
shared_sram.sv
wb_arbiter.sv
weight_loader.sv
act_loader.sv
mac_column_array.sv
matvec_top.sv
matvec_sva.sv
tb_matvec.sv

// File: matvec_patterns.txt
// matvec jobs, one per line, all values hex
// w_base a_base | W[r][c] row-major (16) | x[0..3] | expected y[0..3]

// ramp weights and activations
00 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 0005a 00064 0006e 00078

// largest operands everywhere
20 30 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff 3f804 3f804 3f804 3f804

// identity matrix passes x through
40 50 01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01 11 22 33 44 00011 00022 00033 00044

// activation vector just below the weights
60 5c 10 00 20 03 00 80 01 02 07 00 00 ff 02 02 02 02 03 ff 10 80 001a0 08080 0025f 012f7

// sparse first row, high addresses
a0 f0 00 00 00 00 01 01 01 01 02 04 08 10 80 40 20 ff 09 05 0a 02 00119 000ad 00095 002a3

// same bases as the first job with new contents
00 10 03 03 03 03 03 03 03 03 03 03 03 03 03 03 03 03 01 02 03 04 0001e 0001e 0001e 0001e

// File: matvec_sva.sv
`timescale 1ns/1ns

module matvec_sva (
  input logic                             clk,
  input logic                             rst_n,
  input logic [mv_wb_pkg::N_MASTERS-1:0]  grant_q,
  input logic [mv_wb_pkg::N_MASTERS-1:0]  cyc_vec,
  input mv_wb_pkg::wb_rsp_t               m_rsp [mv_wb_pkg::N_MASTERS],
  input mv_wb_pkg::wb_rsp_t               s_rsp
);
  import mv_wb_pkg::*;

  logic [N_MASTERS-1:0] ack_vec;
  int                   fail_count = 0;

  always_comb begin
    for (int i = 0; i < N_MASTERS; i++) begin
      ack_vec[i] = m_rsp[i].ack;
    end
  end

  // at most one owner on the bus
  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(grant_q))
    else begin
      fail_count++;
      $error("arbiter grant is not one-hot: %b", grant_q);
    end

  // owner keeps the bus while its cyc is high
  grant_held: assert property (@(posedge clk) disable iff (!rst_n)
    |(grant_q & cyc_vec) |=> $stable(grant_q))
    else begin
      fail_count++;
      $error("arbiter grant moved while the owner held cyc");
    end

  // ack lands on the master whose request the memory sampled, still holding cyc
  ack_routed: assert property (@(posedge clk) disable iff (!rst_n)
    s_rsp.ack |-> (ack_vec == $past(grant_q)) && |(grant_q & cyc_vec))
    else begin
      fail_count++;
      $error("ack reached a master without grant: ack %b grant %b", ack_vec, grant_q);
    end

endmodule

bind wb_arbiter matvec_sva matvec_sva_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .grant_q (grant_q),
  .cyc_vec (cyc_vec),
  .m_rsp   (m_rsp),
  .s_rsp   (s_rsp)
);

// File: matvec_top.sv
`timescale 1ns/1ns

module matvec_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  mv_wb_pkg::wb_req_t      host_req,
  output mv_wb_pkg::wb_rsp_t      host_rsp,
  input  logic                    start,
  input  mv_types_pkg::job_t      job,
  output logic                    busy,
  output logic                    done,
  output mv_types_pkg::acc_vec_t  y_vec
);
  import mv_types_pkg::*;
  import mv_wb_pkg::*;

  wb_req_t  m_req [N_MASTERS];
  wb_rsp_t  m_rsp [N_MASTERS];
  wb_req_t  s_req;
  wb_rsp_t  s_rsp;

  logic     loaders_start;
  addr_t    w_base;
  addr_t    a_base;
  logic     w_loaded;
  logic     a_loaded;
  row_idx_t rd_row;
  w_row_t   w_row;
  act_vec_t acts;

  // host takes slot 0 on the bus
  assign m_req[M_HOST] = host_req;
  assign host_rsp      = m_rsp[M_HOST];

  shared_sram shared_sram_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (s_req),
    .rsp   (s_rsp)
  );

  wb_arbiter wb_arbiter_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .m_req (m_req),
    .m_rsp (m_rsp),
    .s_req (s_req),
    .s_rsp (s_rsp)
  );

  weight_loader weight_loader_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (loaders_start),
    .w_base  (w_base),
    .bus_req (m_req[M_WLOAD]),
    .bus_rsp (m_rsp[M_WLOAD]),
    .loaded  (w_loaded),
    .rd_row  (rd_row),
    .w_row   (w_row)
  );

  act_loader act_loader_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (loaders_start),
    .a_base  (a_base),
    .bus_req (m_req[M_ALOAD]),
    .bus_rsp (m_rsp[M_ALOAD]),
    .loaded  (a_loaded),
    .acts    (acts)
  );

  mac_column_array mac_column_array_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .job           (job),
    .loaders_start (loaders_start),
    .w_base        (w_base),
    .a_base        (a_base),
    .w_loaded      (w_loaded),
    .a_loaded      (a_loaded),
    .rd_row        (rd_row),
    .w_row         (w_row),
    .acts          (acts),
    .busy          (busy),
    .done          (done),
    .y_vec         (y_vec)
  );

endmodule

// File: mv_types_pkg.sv
package mv_types_pkg;

  // matrix shape
  localparam int N_ROWS = 4;
  localparam int N_COLS = 4;

  // datapath widths
  localparam int DATA_W = 8;
  localparam int ACC_W  = 20;
  localparam int ADDR_W = 8;

  localparam int MEM_WORDS = 1 << ADDR_W;
  localparam int ROW_W     = $clog2(N_ROWS);
  localparam int COL_W     = $clog2(N_COLS);

  // weight or activation word
  typedef logic [DATA_W-1:0] data_t;

  // 4 products of 8x8 bits never exceed 18 bits
  typedef logic [ACC_W-1:0] acc_t;

  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [ROW_W-1:0] row_idx_t;
  typedef logic [COL_W-1:0] col_idx_t;

  // one matrix row as seen across all column banks
  typedef data_t [N_COLS-1:0] w_row_t;

  typedef acc_t [N_COLS-1:0] acc_vec_t;
  typedef data_t [N_ROWS-1:0] act_vec_t;

  // weight matrix and activation vector base addresses
  typedef struct packed {
    addr_t w_base;
    addr_t a_base;
  } job_t;

endpackage

// File: mv_wb_pkg.sv
package mv_wb_pkg;

  localparam int N_MASTERS = 3;
  localparam int MST_W     = $clog2(N_MASTERS);

  // master slots on the arbiter
  localparam int M_HOST  = 0;
  localparam int M_WLOAD = 1;
  localparam int M_ALOAD = 2;

  typedef logic [MST_W-1:0] master_idx_t;

  // wishbone classic master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    mv_types_pkg::addr_t adr;
    mv_types_pkg::data_t dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                ack;
    mv_types_pkg::data_t dat;
  } wb_rsp_t;

endpackage

// File: shared_sram.sv
`timescale 1ns/1ns

module shared_sram (
  input  logic                clk,
  input  logic                rst_n,
  input  mv_wb_pkg::wb_req_t  req,
  output mv_wb_pkg::wb_rsp_t  rsp
);
  import mv_types_pkg::*;

  data_t mem [MEM_WORDS];

  logic  ack_q;
  data_t rd_q;
  logic  access;

  // a new transfer is taken only when no ack is out
  assign access = req.cyc && req.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // write lands at sample time, ack follows one cycle later
  always_ff @(posedge clk) begin
    if (access) begin
      if (req.we) begin
        mem[req.adr] <= req.dat;
      end
      rd_q <= mem[req.adr];
    end
  end

  always_comb begin
    rsp.ack = ack_q;
    rsp.dat = rd_q;
  end

endmodule

// File: tb_matvec.sv
`timescale 1ns/1ns

module tb_matvec;
  import mv_types_pkg::*;
  import mv_wb_pkg::*;

  localparam int CLK_HALF   = 10;
  localparam int DRIVE_DLY  = 2;
  localparam int RST_CYCLES = 16;
  localparam int JOB_WORDS  = 2 + N_ROWS * N_COLS + N_ROWS + N_COLS;
  localparam int MAX_JOBS   = 8;
  localparam int ACK_LIMIT  = 200;
  localparam int DONE_LIMIT = 400;
  localparam int CHK_W      = N_COLS * ACC_W;

  typedef logic [CHK_W-1:0] chk_t;

  logic     clk;
  logic     rst_n;
  wb_req_t  host_req;
  wb_rsp_t  host_rsp;
  logic     start;
  job_t     job;
  logic     busy;
  logic     done;
  acc_vec_t y_vec;

  logic [ACC_W-1:0] pat [MAX_JOBS * JOB_WORDS];
  data_t    shadow [MEM_WORDS];
  addr_t    written [$];
  int       n_jobs;
  logic     pat_ready;
  int       value_errors;
  int       other_errors;
  int       done_count;
  acc_vec_t y_hold;

  matvec_top matvec_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .start    (start),
    .job      (job),
    .busy     (busy),
    .done     (done),
    .y_vec    (y_vec)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  task automatic check_value(input string name, input chk_t exp, input chk_t got);
    assert (got === exp) else begin
      value_errors++;
      $display("Error: time %0t %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  // count done pulses, y_vec must hold between them
  always @(negedge clk) begin
    if (rst_n) begin
      if (done) begin
        done_count = done_count + 1;
        y_hold = y_vec;
      end else begin
        check_value("y_vec (held)", y_hold, y_vec);
      end
    end
  end

  function automatic job_t job_of(input int j);
    job_t jb;
    jb.w_base = pat[j * JOB_WORDS][ADDR_W-1:0];
    jb.a_base = pat[j * JOB_WORDS + 1][ADDR_W-1:0];
    return jb;
  endfunction

  function automatic data_t w_of(input int j, input int r, input int c);
    return pat[j * JOB_WORDS + 2 + r * N_COLS + c][DATA_W-1:0];
  endfunction

  function automatic data_t x_of(input int j, input int r);
    return pat[j * JOB_WORDS + 2 + N_ROWS * N_COLS + r][DATA_W-1:0];
  endfunction

  function automatic acc_vec_t exp_of(input int j);
    acc_vec_t y;
    for (int c = 0; c < N_COLS; c++) begin
      y[c] = pat[j * JOB_WORDS + 2 + N_ROWS * N_COLS + N_ROWS + c];
    end
    return y;
  endfunction

  // y[c] = sum over r of W[r][c] * x[r], unsigned
  function automatic acc_vec_t ref_matvec(input int j);
    acc_vec_t y;
    y = '0;
    for (int c = 0; c < N_COLS; c++) begin
      for (int r = 0; r < N_ROWS; r++) begin
        y[c] = y[c] + acc_t'(w_of(j, r, c)) * acc_t'(x_of(j, r));
      end
    end
    return y;
  endfunction

  // one wishbone classic transfer, ack sampled on the falling edge
  task automatic host_xfer(input logic we, input addr_t adr, input data_t wdat,
                           output data_t rdat);
    int waited;
    @(posedge clk);
    #DRIVE_DLY;
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = we;
    host_req.adr = adr;
    host_req.dat = wdat;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!host_rsp.ack && waited < ACK_LIMIT);
    rdat = host_rsp.dat;
    assert (host_rsp.ack) else begin
      other_errors++;
      $display("Error: time %0t host access to %02h got no ack", $time, adr);
    end
    @(posedge clk);
    #DRIVE_DLY;
    host_req = '0;
  endtask

  task automatic host_write(input addr_t adr, input data_t wdat);
    data_t rd_dummy;
    host_xfer(1'b1, adr, wdat, rd_dummy);
    shadow[adr] = wdat;
    written.push_back(adr);
  endtask

  task automatic host_read_check(input addr_t adr);
    data_t rd;
    host_xfer(1'b0, adr, '0, rd);
    check_value($sformatf("host_rsp.dat @%02h", adr), chk_t'(shadow[adr]), chk_t'(rd));
  endtask

  task automatic random_reads(input int count);
    for (int i = 0; i < count; i++) begin
      repeat ($urandom_range(3)) @(posedge clk);
      host_read_check(written[$urandom_range(written.size() - 1)]);
    end
  endtask

  task automatic preload_job(input int j);
    job_t jb;
    jb = job_of(j);
    for (int r = 0; r < N_ROWS; r++) begin
      for (int c = 0; c < N_COLS; c++) begin
        host_write(addr_t'(int'(jb.w_base) + r * N_COLS + c), w_of(j, r, c));
      end
      host_write(addr_t'(int'(jb.a_base) + r), x_of(j, r));
    end
  endtask

  task automatic pulse_start(input job_t jb);
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b1;
    job   = jb;
    @(posedge clk);
    #DRIVE_DLY;
    start = 1'b0;
    @(negedge clk);
    check_value("busy", chk_t'(1'b1), chk_t'(busy));
  endtask

  task automatic wait_done(input int target);
    int waited;
    waited = 0;
    while (done_count < target && waited < DONE_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    assert (done_count >= target) else begin
      other_errors++;
      $display("Error: time %0t no done pulse within %0d cycles", $time, DONE_LIMIT);
    end
  endtask

  task automatic run_job(input int j, input int traffic);
    int target;
    check_value($sformatf("pattern %0d expected y", j), ref_matvec(j), exp_of(j));
    preload_job(j);
    target = done_count + 1;
    pulse_start(job_of(j));
    // host reads stall behind the loaders while the job runs
    random_reads(traffic);
    wait_done(target);
    check_value($sformatf("y_vec job %0d", j), exp_of(j), y_vec);
  endtask

  // second start arrives while busy and must be dropped
  task automatic ignored_start(input int j, input int k);
    int target;
    preload_job(j);
    target = done_count + 1;
    pulse_start(job_of(j));
    repeat (3) @(posedge clk);
    pulse_start(job_of(k));
    wait_done(target);
    check_value($sformatf("y_vec job %0d", j), exp_of(j), y_vec);
    repeat (100) @(posedge clk);
    assert (done_count == target) else begin
      other_errors++;
      $display("Error: time %0t a start during busy launched another job", $time);
    end
    check_value("busy", '0, chk_t'(busy));
  endtask

  initial begin
    int sva_fails;
    void'($urandom(86));
    rst_n        = 1'b0;
    host_req     = '0;
    start        = 1'b0;
    job          = '0;
    value_errors = 0;
    other_errors = 0;
    done_count   = 0;
    y_hold       = '0;
    pat_ready    = 1'b0;
    n_jobs       = 0;
    for (int i = 0; i < MAX_JOBS * JOB_WORDS; i++) begin
      pat[i] = '1;
    end
    $readmemh("matvec_patterns.txt", pat);
    // unused slots keep the all-ones fill, which no base address reaches
    while (n_jobs < MAX_JOBS && pat[n_jobs * JOB_WORDS] != '1) begin
      n_jobs++;
    end
    pat_ready = 1'b1;
    assert (n_jobs > 0) else begin
      other_errors++;
      $display("Error: no jobs found in matvec_patterns.txt");
    end

    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    @(negedge clk);
    check_value("busy", '0, chk_t'(busy));
    check_value("done", '0, chk_t'(done));
    check_value("host_rsp.ack", '0, chk_t'(host_rsp.ack));
    check_value("y_vec", '0, y_vec);

    for (int i = 0; i < 8; i++) begin
      host_write(addr_t'($urandom_range(MEM_WORDS - 1)), data_t'($urandom_range(255)));
    end
    random_reads(8);

    // back to back, every other job with host traffic while busy
    for (int j = 0; j < n_jobs; j++) begin
      run_job(j, (j % 2 == 1) ? 4 : 0);
    end
    if (n_jobs > 1) begin
      ignored_start(0, 1);
    end

    sva_fails = matvec_top_inst.wb_arbiter_inst.matvec_sva_inst.fail_count;
    $display("errors: %0d value, %0d other, %0d assertion",
             value_errors, other_errors, sva_fails);
    if (value_errors == 0 && other_errors == 0 && sva_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // watchdog scaled by the number of jobs
  initial begin
    wait (pat_ready);
    repeat (n_jobs * 400 + 2000) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", n_jobs * 400 + 2000);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: wb_arbiter.sv
`timescale 1ns/1ns

module wb_arbiter (
  input  logic                clk,
  input  logic                rst_n,
  input  mv_wb_pkg::wb_req_t  m_req [mv_wb_pkg::N_MASTERS],
  output mv_wb_pkg::wb_rsp_t  m_rsp [mv_wb_pkg::N_MASTERS],
  output mv_wb_pkg::wb_req_t  s_req,
  input  mv_wb_pkg::wb_rsp_t  s_rsp
);
  import mv_wb_pkg::*;

  logic [N_MASTERS-1:0] cyc_vec;
  logic [N_MASTERS-1:0] grant_q;
  logic [N_MASTERS-1:0] pick;
  master_idx_t          pick_idx;
  master_idx_t          last_q;
  logic                 owner_cyc;

  always_comb begin
    for (int i = 0; i < N_MASTERS; i++) begin
      cyc_vec[i] = m_req[i].cyc;
    end
  end

  // the grant may only move once the owner has let go of cyc
  assign owner_cyc = |(grant_q & cyc_vec);

  // walk from the slot after the last owner, nearest one wins
  always_comb begin
    int idx;
    pick     = '0;
    pick_idx = last_q;
    for (int k = N_MASTERS; k >= 1; k--) begin
      idx = (int'(last_q) + k) % N_MASTERS;
      if (cyc_vec[idx]) begin
        pick      = '0;
        pick[idx] = 1'b1;
        pick_idx  = master_idx_t'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      grant_q <= '0;
      // host gets first turn after reset
      last_q  <= master_idx_t'(N_MASTERS - 1);
    end else if (!owner_cyc) begin
      grant_q <= pick;
      if (|pick) begin
        last_q <= pick_idx;
      end
    end
  end

  // one-hot mux toward the memory
  always_comb begin
    s_req = '0;
    for (int i = 0; i < N_MASTERS; i++) begin
      if (grant_q[i]) begin
        s_req = m_req[i];
      end
    end
  end

  // losers see ack low and keep waiting
  always_comb begin
    for (int i = 0; i < N_MASTERS; i++) begin
      m_rsp[i].ack = grant_q[i] & s_rsp.ack;
      m_rsp[i].dat = grant_q[i] ? s_rsp.dat : '0;
    end
  end

endmodule

// File: weight_loader.sv
`timescale 1ns/1ns

module weight_loader (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  mv_types_pkg::addr_t     w_base,
  output mv_wb_pkg::wb_req_t      bus_req,
  input  mv_wb_pkg::wb_rsp_t      bus_rsp,
  output logic                    loaded,
  input  mv_types_pkg::row_idx_t  rd_row,
  output mv_types_pkg::w_row_t    w_row
);
  import mv_types_pkg::*;

  typedef enum logic [1:0] {
    W_IDLE,
    W_FETCH,
    W_DONE
  } w_state_t;

  w_state_t state_q;
  addr_t    addr_q;
  row_idx_t row_q;
  col_idx_t col_q;
  logic     last_col;
  logic     last_word;

  // one bank per column, each deep enough for a whole column
  data_t bank [N_COLS][N_ROWS];

  assign last_col  = (col_q == col_idx_t'(N_COLS - 1));
  assign last_word = last_col && (row_q == row_idx_t'(N_ROWS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= W_IDLE;
      addr_q  <= '0;
      row_q   <= '0;
      col_q   <= '0;
    end else begin
      case (state_q)
        W_IDLE, W_DONE: begin
          if (start) begin
            state_q <= W_FETCH;
            addr_q  <= w_base;
            row_q   <= '0;
            col_q   <= '0;
          end
        end
        W_FETCH: begin
          // row-major memory, so the column index runs fastest
          if (bus_rsp.ack) begin
            addr_q <= addr_q + 1'b1;
            col_q  <= col_q + 1'b1;
            if (last_col) begin
              row_q <= row_q + 1'b1;
            end
            if (last_word) begin
              state_q <= W_DONE;
            end
          end
        end
        default: state_q <= W_IDLE;
      endcase
    end
  end

  // scatter the returned word into its column bank
  always_ff @(posedge clk) begin
    if (state_q == W_FETCH && bus_rsp.ack) begin
      bank[col_q][row_q] <= bus_rsp.dat;
    end
  end

  always_comb begin
    for (int c = 0; c < N_COLS; c++) begin
      w_row[c] = bank[c][rd_row];
    end
  end

  // cyc held for the whole 16-word burst
  always_comb begin
    bus_req     = '0;
    bus_req.cyc = (state_q == W_FETCH);
    bus_req.stb = (state_q == W_FETCH);
    bus_req.adr = addr_q;
  end

  assign loaded = (state_q == W_DONE);

endmodule
